/* hw/psram_access_fsm.sv */
`timescale 1ns/1ps

module psram_access_fsm (
    input  logic                    clk50MHz,
    input  logic                    rst_n,
    input  logic                    head_valid,
    input  psram_pkg::psram_req_t   head,
    output logic                    head_pop,
    input  psram_pkg::beat_count_t  wfifo_level,
    output logic                    wbeat_take,
    output logic                    bus_drive,
    output logic                    rbeat_capture,
    output logic                    done,
    output psram_pkg::psram_addr_t  maddr,
    output logic                    mce_n,
    output logic                    madv_n,
    output logic                    moe_n,
    output logic                    mwe_n,
    output logic                    mclk
);

    psram_pkg::access_state_t state;
    psram_pkg::access_state_t next_state;

    psram_pkg::psram_req_t req_q;

    logic [psram_pkg::lat_cnt_bits-1:0] lat_cnt;
    psram_pkg::beat_count_t             beat_cnt;
    psram_pkg::beat_count_t             beat_last;

    logic lat_done;
    logic beat_done;
    logic head_ready;
    logic in_wait;
    logic in_data;
    logic active;
    logic mclk_en;

    // A write starts only once its whole burst sits in the write FIFO
    assign head_ready = !head.write || (wfifo_level >= psram_pkg::burst_len(head.burst));
    assign head_pop   = (state == psram_pkg::st_idle) && head_valid && head_ready;

    assign in_wait = (state == psram_pkg::st_read_wait) || (state == psram_pkg::st_write_wait);
    assign in_data = (state == psram_pkg::st_read_data) || (state == psram_pkg::st_write_data);
    assign active  = (state == psram_pkg::st_addr) || in_wait || in_data;

    assign beat_last = psram_pkg::burst_len(req_q.burst) - 4'd1;
    assign lat_done  = (lat_cnt == psram_pkg::lat_cnt_bits'(psram_pkg::rw_latency_cycles - 1));
    assign beat_done = (beat_cnt == beat_last);

    // Latched request for the running access
    always_ff @(posedge clk50MHz) begin
        if (head_pop) begin
            req_q <= head;
        end
    end

    always_ff @(posedge clk50MHz or negedge rst_n) begin
        if (!rst_n) begin
            state    <= psram_pkg::st_idle;
            lat_cnt  <= '0;
            beat_cnt <= '0;
        end else begin
            state <= next_state;
            // Counters run only in their own phase and clear otherwise
            if (in_wait) begin
                lat_cnt <= lat_cnt + 1'b1;
            end else begin
                lat_cnt <= '0;
            end
            if (in_data) begin
                beat_cnt <= beat_cnt + 4'd1;
            end else begin
                beat_cnt <= '0;
            end
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            psram_pkg::st_idle: begin
                if (head_pop) begin
                    next_state = psram_pkg::st_addr;
                end
            end
            psram_pkg::st_addr: begin
                if (req_q.write) begin
                    next_state = psram_pkg::st_write_wait;
                end else begin
                    next_state = psram_pkg::st_read_wait;
                end
            end
            psram_pkg::st_read_wait: begin
                if (lat_done) begin
                    next_state = psram_pkg::st_read_data;
                end
            end
            psram_pkg::st_write_wait: begin
                if (lat_done) begin
                    next_state = psram_pkg::st_write_data;
                end
            end
            psram_pkg::st_read_data,
            psram_pkg::st_write_data: begin
                if (beat_done) begin
                    next_state = psram_pkg::st_finish;
                end
            end
            psram_pkg::st_finish: begin
                next_state = psram_pkg::st_idle;
            end
            default: begin
                next_state = psram_pkg::st_idle;
            end
        endcase
    end

    // Device control pins are all active low
    always_comb begin
        mce_n  = !active;
        madv_n = (state != psram_pkg::st_addr);
        moe_n  = (state != psram_pkg::st_read_data);
        mwe_n  = !(req_q.write && active);
    end

    assign wbeat_take    = (state == psram_pkg::st_write_data);
    assign bus_drive     = (state == psram_pkg::st_write_data);
    assign rbeat_capture = (state == psram_pkg::st_read_data);
    assign done          = (state == psram_pkg::st_finish);

    // Device bursts count addresses internally
    assign maddr = req_q.addr;

    // Gate enable changes while clk50MHz is low so mclk never glitches
    always_ff @(negedge clk50MHz or negedge rst_n) begin
        if (!rst_n) begin
            mclk_en <= 1'b0;
        end else begin
            mclk_en <= active;
        end
    end

    assign mclk = clk50MHz & mclk_en;

endmodule

/* hw/psram_data_path.sv */
`timescale 1ns/1ps

module psram_data_path (
    input  logic                    clk50MHz,
    input  logic                    rst_n,
    input  logic                    wdata_valid,
    output logic                    wdata_ready,
    input  psram_pkg::psram_data_t  wdata,
    input  logic                    wbeat_take,
    output psram_pkg::beat_count_t  wfifo_level,
    input  logic                    bus_drive,
    input  logic                    rbeat_capture,
    inout  psram_pkg::psram_data_t  dq,
    output logic                    rdata_valid,
    output psram_pkg::psram_data_t  rdata
);

    psram_pkg::psram_data_t wfifo_mem [psram_pkg::wfifo_depth];

    logic [psram_pkg::wfifo_ptr_bits-1:0] wr_ptr;
    logic [psram_pkg::wfifo_ptr_bits-1:0] rd_ptr;
    psram_pkg::beat_count_t               level;

    logic push;
    logic pop;

    assign wdata_ready = (level != 4'(psram_pkg::wfifo_depth));
    assign wfifo_level = level;

    assign push = wdata_valid && wdata_ready;
    // FSM only takes beats it already saw in the level
    assign pop  = wbeat_take;

    always_ff @(posedge clk50MHz) begin
        if (push) begin
            wfifo_mem[wr_ptr] <= wdata;
        end
    end

    always_ff @(posedge clk50MHz or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10: level <= level + 4'd1;
                2'b01: level <= level - 4'd1;
                default: level <= level;
            endcase
        end
    end

    // Head of the FIFO goes out on the bus during write data beats
    assign dq = bus_drive ? wfifo_mem[rd_ptr] : 'z;

    // Read capture
    always_ff @(posedge clk50MHz) begin
        if (rbeat_capture) begin
            rdata <= dq;
        end
    end

    always_ff @(posedge clk50MHz or negedge rst_n) begin
        if (!rst_n) begin
            rdata_valid <= 1'b0;
        end else begin
            rdata_valid <= rbeat_capture;
        end
    end

endmodule

/* hw/psram_pkg.sv */
package psram_pkg;

    // Device geometry
    localparam int addr_bits = 24;
    localparam int data_bits = 16;

    // Fixed access latency in memory clocks
    localparam int rw_latency_cycles = 4;
    localparam int lat_cnt_bits = $clog2(rw_latency_cycles);

    // Write-beat buffer, one full 8-word burst
    localparam int wfifo_depth = 8;
    localparam int wfifo_ptr_bits = $clog2(wfifo_depth);

    typedef logic [addr_bits-1:0] psram_addr_t;
    typedef logic [data_bits-1:0] psram_data_t;
    typedef logic [1:0] burst_code_t;
    typedef logic [3:0] beat_count_t;

    typedef struct packed {
        psram_addr_t addr;
        burst_code_t burst;
        logic        write;
    } psram_req_t;

    typedef enum logic [2:0] {
        st_idle,
        st_addr,
        st_read_wait,
        st_read_data,
        st_write_wait,
        st_write_data,
        st_finish
    } access_state_t;

    // Burst code to number of words
    function automatic beat_count_t burst_len(input burst_code_t code);
        beat_count_t len;
        case (code)
            2'd0: len = 4'd1;
            2'd1: len = 4'd2;
            2'd2: len = 4'd4;
            default: len = 4'd8;
        endcase
        return len;
    endfunction

endpackage

/* hw/psram_request_queue.sv */
`timescale 1ns/1ps

module psram_request_queue (
    input  logic                   clk50MHz,
    input  logic                   rst_n,
    input  logic                   req_valid,
    output logic                   req_ready,
    input  psram_pkg::psram_req_t  req,
    output logic                   head_valid,
    output psram_pkg::psram_req_t  head,
    input  logic                   head_pop
);

    psram_pkg::psram_req_t entries [2];

    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;
    logic       push;
    logic       pop;

    assign req_ready  = (count != 2'd2);
    assign head_valid = (count != 2'd0);
    assign head       = entries[rd_ptr];

    assign push = req_valid && req_ready;
    assign pop  = head_pop && head_valid;

    // Entry storage carries payload only
    always_ff @(posedge clk50MHz) begin
        if (push) begin
            entries[wr_ptr] <= req;
        end
    end

    always_ff @(posedge clk50MHz or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop) begin
                rd_ptr <= ~rd_ptr;
            end
            // Simultaneous push and pop keeps the count
            case ({push, pop})
                2'b10: count <= count + 2'd1;
                2'b01: count <= count - 2'd1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* hw/psram_subsystem.sv */
`timescale 1ns/1ps

module psram_subsystem (
    input  logic                    clk50MHz,
    input  logic                    rst_n,

    // Host request port
    input  logic                    req_valid,
    output logic                    req_ready,
    input  psram_pkg::psram_req_t   req,

    // Write data stream
    input  logic                    wdata_valid,
    output logic                    wdata_ready,
    input  psram_pkg::psram_data_t  wdata,

    // Read data stream, no back-pressure
    output logic                    rdata_valid,
    output psram_pkg::psram_data_t  rdata,

    output logic                    done,

    // Device pins
    output psram_pkg::psram_addr_t  maddr,
    inout  psram_pkg::psram_data_t  dq,
    output logic                    mce_n,
    output logic                    madv_n,
    output logic                    moe_n,
    output logic                    mwe_n,
    output logic                    mclk,
    output logic                    mub_n,
    output logic                    mlb_n,
    output logic                    mcre
);

    logic                   head_valid;
    psram_pkg::psram_req_t  head;
    logic                   head_pop;
    psram_pkg::beat_count_t wfifo_level;
    logic                   wbeat_take;
    logic                   bus_drive;
    logic                   rbeat_capture;

    // Full-word accesses, control register never selected
    assign mub_n = 1'b0;
    assign mlb_n = 1'b0;
    assign mcre  = 1'b0;

    psram_request_queue i_queue (
        .clk50MHz   (clk50MHz),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req        (req),
        .head_valid (head_valid),
        .head       (head),
        .head_pop   (head_pop)
    );

    psram_access_fsm i_fsm (
        .clk50MHz      (clk50MHz),
        .rst_n         (rst_n),
        .head_valid    (head_valid),
        .head          (head),
        .head_pop      (head_pop),
        .wfifo_level   (wfifo_level),
        .wbeat_take    (wbeat_take),
        .bus_drive     (bus_drive),
        .rbeat_capture (rbeat_capture),
        .done          (done),
        .maddr         (maddr),
        .mce_n         (mce_n),
        .madv_n        (madv_n),
        .moe_n         (moe_n),
        .mwe_n         (mwe_n),
        .mclk          (mclk)
    );

    psram_data_path i_data_path (
        .clk50MHz      (clk50MHz),
        .rst_n         (rst_n),
        .wdata_valid   (wdata_valid),
        .wdata_ready   (wdata_ready),
        .wdata         (wdata),
        .wbeat_take    (wbeat_take),
        .wfifo_level   (wfifo_level),
        .bus_drive     (bus_drive),
        .rbeat_capture (rbeat_capture),
        .dq            (dq),
        .rdata_valid   (rdata_valid),
        .rdata         (rdata)
    );

endmodule

/* psram_ctrl.f */
hw/psram_pkg.sv
hw/psram_request_queue.sv
hw/psram_access_fsm.sv
hw/psram_data_path.sv
hw/psram_subsystem.sv
verification/psram_model.sv
verification/tb_psram_subsystem.sv

/* verification/psram_model.sv */
`timescale 1ns/1ps

module psram_model (
    input  logic                    mclk,
    input  logic                    mce_n,
    input  logic                    madv_n,
    input  logic                    moe_n,
    input  logic                    mwe_n,
    input  logic                    mub_n,
    input  logic                    mlb_n,
    input  psram_pkg::psram_addr_t  maddr,
    inout  psram_pkg::psram_data_t  dq
);

    // Only the low 4K words are modeled, higher address bits alias
    localparam int mem_words = 4096;

    psram_pkg::psram_data_t mem [mem_words];
    psram_pkg::psram_addr_t base;
    psram_pkg::psram_data_t dout;

    logic is_write;
    logic in_burst;
    int   cyc;
    int   idx;

    initial begin
        in_burst = 1'b0;
        is_write = 1'b0;
        cyc      = 0;
        dout     = '0;
    end

    // Output buffer follows OE# while the chip is selected
    assign dq = (!mce_n && !moe_n) ? dout : 'z;

    // Pins are taken as they stood just before each rising mclk edge
    always @(posedge mclk) begin
        if (mce_n) begin
            in_burst = 1'b0;
        end else if (!madv_n) begin
            // Address and direction latched with ADV# low
            base     = maddr;
            is_write = !mwe_n;
            cyc      = 0;
            in_burst = 1'b1;
        end else if (in_burst) begin
            cyc = cyc + 1;
            if (!is_write && cyc >= psram_pkg::rw_latency_cycles) begin
                idx = (int'(base) + cyc - psram_pkg::rw_latency_cycles) % mem_words;
                // Clock to output delay
                dout <= #1 mem[idx];
            end
            if (is_write && cyc > psram_pkg::rw_latency_cycles) begin
                idx = (int'(base) + cyc - psram_pkg::rw_latency_cycles - 1) % mem_words;
                if (!mlb_n) begin
                    mem[idx][7:0] = dq[7:0];
                end
                if (!mub_n) begin
                    mem[idx][15:8] = dq[15:8];
                end
            end
        end
    end

endmodule

/* verification/tb_psram_subsystem.sv */
`timescale 1ns/1ps

module tb_psram_subsystem;

    // Longest access is 14 cycles; five tests with about twenty accesses stay near 500
    localparam int cycle_limit = 4000;
    localparam int sb_words = 4096;

    logic                   clk50MHz;
    logic                   rst_n;
    logic                   req_valid;
    logic                   req_ready;
    psram_pkg::psram_req_t  req;
    logic                   wdata_valid;
    logic                   wdata_ready;
    psram_pkg::psram_data_t wdata;
    logic                   rdata_valid;
    psram_pkg::psram_data_t rdata;
    logic                   done;
    psram_pkg::psram_addr_t maddr;
    wire psram_pkg::psram_data_t dq;
    logic                   mce_n;
    logic                   madv_n;
    logic                   moe_n;
    logic                   mwe_n;
    logic                   mclk;
    logic                   mub_n;
    logic                   mlb_n;
    logic                   mcre;

    // Scoreboard of written words and logs of what the DUT did
    psram_pkg::psram_data_t sb_mem [sb_words];
    psram_pkg::psram_data_t rd_q [$];
    psram_pkg::psram_addr_t start_addr_q [$];
    int rd_cyc_q [$];
    int done_cyc_q [$];
    int start_cyc_q [$];

    int   cycles = 0;
    int   errors = 0;
    int   checks = 0;
    int   mark = 0;
    int   seed = 73959;
    logic mce_q = 1'b1;

    psram_subsystem i_dut (.*);
    psram_model i_mem (.*);

    initial begin
        clk50MHz = 1'b0;
        forever #10 clk50MHz = ~clk50MHz;
    end

    always @(posedge clk50MHz) cycles <= cycles + 1;

    initial begin
        wait (cycles >= cycle_limit);
        $display("Timeout: tests did not finish within %0d cycles", cycle_limit);
        $display("ERRORS FOUND");
        $finish;
    end

    // Access starts are taken mid-cycle where CE# falls
    always @(negedge clk50MHz) begin
        if (rst_n) begin
            if (!mce_n && mce_q) begin
                start_cyc_q.push_back(cycles);
                start_addr_q.push_back(maddr);
            end
            if (rdata_valid) begin
                rd_q.push_back(rdata);
                rd_cyc_q.push_back(cycles);
            end
            if (done) begin
                done_cyc_q.push_back(cycles);
            end
        end
        mce_q = mce_n;
    end

    task automatic check_data(input string name, input psram_pkg::psram_data_t got,
                              input psram_pkg::psram_data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input psram_pkg::psram_addr_t got,
                              input psram_pkg::psram_addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_pin(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("Error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk50MHz);
        #2;
    endtask

    function automatic psram_pkg::psram_addr_t rand_addr();
        int r;
        r = $random(seed);
        return {12'h000, r[11:0]};
    endfunction

    task automatic clear_logs();
        rd_q.delete();
        rd_cyc_q.delete();
        done_cyc_q.delete();
        start_cyc_q.delete();
        start_addr_q.delete();
    endtask

    task automatic finish_test(input string name);
        $display("Test %s finished with %0d errors", name, errors - mark);
        mark = errors;
    endtask

    task automatic send_req(input psram_pkg::psram_addr_t a, input psram_pkg::burst_code_t code,
                            input logic is_write);
        req_valid = 1'b1;
        req.addr  = a;
        req.burst = code;
        req.write = is_write;
        while (!req_ready) begin
            next_cycle();
        end
        next_cycle();
        req_valid = 1'b0;
    endtask

    task automatic push_beat(input psram_pkg::psram_data_t d);
        wdata_valid = 1'b1;
        wdata       = d;
        while (!wdata_ready) begin
            next_cycle();
        end
        next_cycle();
        wdata_valid = 1'b0;
    endtask

    task automatic wait_done(input int n);
        while (done_cyc_q.size() < n) begin
            next_cycle();
        end
    endtask

    // Buffers a random burst and records it in the scoreboard before the request goes out
    task automatic write_burst(input psram_pkg::psram_addr_t a,
                               input psram_pkg::burst_code_t code);
        int target;
        psram_pkg::psram_data_t d;
        target = done_cyc_q.size() + 1;
        for (int k = 0; k < (1 << code); k++) begin
            d = psram_pkg::psram_data_t'($random(seed));
            sb_mem[(int'(a) + k) % sb_words] = d;
            push_beat(d);
        end
        // A full 8-word burst fills the empty write FIFO
        check_pin("wdata_ready", wdata_ready, (1 << code) < psram_pkg::wfifo_depth);
        send_req(a, code, 1'b1);
        wait_done(target);
    endtask

    task automatic read_check(input psram_pkg::psram_addr_t a, input psram_pkg::burst_code_t code);
        int target;
        int n;
        n = 1 << code;
        rd_q.delete();
        rd_cyc_q.delete();
        target = done_cyc_q.size() + 1;
        send_req(a, code, 1'b0);
        wait_done(target);
        check_count("read beats", rd_q.size(), n);
        for (int k = 0; k < rd_q.size(); k++) begin
            check_data("rdata", rd_q[k], sb_mem[(int'(a) + k) % sb_words]);
        end
        if (rd_cyc_q.size() > 0) begin
            check_count("read beat span", rd_cyc_q[$] - rd_cyc_q[0], rd_q.size() - 1);
        end
    endtask

    task automatic test_reset();
        check_pin("mce_n", mce_n, 1'b1);
        check_pin("madv_n", madv_n, 1'b1);
        check_pin("moe_n", moe_n, 1'b1);
        check_pin("mwe_n", mwe_n, 1'b1);
        check_pin("mclk", mclk, 1'b0);
        check_pin("mub_n", mub_n, 1'b0);
        check_pin("mlb_n", mlb_n, 1'b0);
        check_pin("mcre", mcre, 1'b0);
        check_pin("rdata_valid", rdata_valid, 1'b0);
        check_pin("done", done, 1'b0);
        check_pin("req_ready", req_ready, 1'b1);
        check_data("dq", dq, 16'hzzzz);
        finish_test("reset_state");
    endtask

    task automatic test_single();
        psram_pkg::psram_addr_t a;
        a = rand_addr();
        clear_logs();
        write_burst(a, 2'd0);
        read_check(a, 2'd0);
        check_count("accesses", start_cyc_q.size(), 2);
        check_count("done pulses", done_cyc_q.size(), 2);
        if (start_cyc_q.size() == 2 && rd_cyc_q.size() > 0 && done_cyc_q.size() == 2) begin
            check_addr("maddr", start_addr_q[0], a);
            check_count("rdata_valid delay", rd_cyc_q[0] - start_cyc_q[1], 6);
            check_count("done delay", done_cyc_q[1] - start_cyc_q[1], 6);
        end
        finish_test("single_word");
    endtask

    task automatic test_bursts();
        psram_pkg::psram_addr_t a;
        for (int code = 0; code < 4; code++) begin
            a = rand_addr();
            write_burst(a, psram_pkg::burst_code_t'(code));
            read_check(a, psram_pkg::burst_code_t'(code));
        end
        finish_test("bursts");
    endtask

    task automatic test_queued();
        psram_pkg::psram_addr_t a [3];
        for (int i = 0; i < 3; i++) begin
            a[i] = rand_addr();
            write_burst(a[i], 2'd0);
        end
        clear_logs();
        for (int i = 0; i < 3; i++) begin
            send_req(a[i], 2'd0, 1'b0);
        end
        // One access running, two waiting
        check_pin("req_ready", req_ready, 1'b0);
        wait_done(3);
        check_count("done pulses", done_cyc_q.size(), 3);
        check_count("read beats", rd_q.size(), 3);
        check_count("accesses", start_addr_q.size(), 3);
        for (int i = 0; i < 3; i++) begin
            if (i < rd_q.size()) begin
                check_data("rdata", rd_q[i], sb_mem[a[i] % sb_words]);
            end
            if (i < start_addr_q.size()) begin
                check_addr("maddr", start_addr_q[i], a[i]);
            end
        end
        finish_test("queued_requests");
    endtask

    task automatic test_late_data();
        psram_pkg::psram_addr_t a;
        psram_pkg::psram_data_t d;
        a = rand_addr();
        clear_logs();
        send_req(a, 2'd2, 1'b1);
        for (int k = 0; k < 4; k++) begin
            d = psram_pkg::psram_data_t'($random(seed));
            sb_mem[(int'(a) + k) % sb_words] = d;
            push_beat(d);
            for (int w = 0; w < 3 && k < 3; w++) begin
                next_cycle();
                check_pin("mce_n", mce_n, 1'b1);
            end
        end
        wait_done(1);
        read_check(a, 2'd2);
        finish_test("write_without_data");
    endtask

    initial begin
        rst_n       = 1'b0;
        req_valid   = 1'b0;
        req         = '0;
        wdata_valid = 1'b0;
        wdata       = '0;
        repeat (5) @(posedge clk50MHz);
        #2;
        rst_n = 1'b1;
        next_cycle();
        test_reset();
        test_single();
        test_bursts();
        test_queued();
        test_late_data();
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
